/* cpu_mem_top.f */
hw/nes_cpu_pkg.sv
hw/mem_inputs.sv
hw/cpu_bus_latches.sv
hw/cpu_memory.sv
hw/ppu_reg_apb_bridge.sv
hw/cpu_mem_top.sv
verification/ppu_reg_model.sv
verification/tb_cpu_mem_top.sv

/* Bender.yml */
package:
  name: cpu_mem_top

sources:
  - hw/nes_cpu_pkg.sv
  - hw/mem_inputs.sv
  - hw/cpu_bus_latches.sv
  - hw/cpu_memory.sv
  - hw/ppu_reg_apb_bridge.sv
  - hw/cpu_mem_top.sv
  - target: test
    files:
      - verification/ppu_reg_model.sv
      - verification/tb_cpu_mem_top.sv

/* verification/tb_cpu_mem_top.sv */
`timescale 1ns/1ps

module tb_cpu_mem_top import nes_cpu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 50;

    typedef struct packed {
        addr_t addr;
        byte_t wdata;
        byte_t rdata;
        logic  is_wram;
        logic  is_ppu;
        logic  is_read;
        logic  is_write;
    } access_t;

    typedef struct packed {
        ppu_reg_idx_t paddr;
        logic         pwrite;
        byte_t        pwdata;
    } apb_xfer_t;

    logic         clock = 1'b0;
    logic         reset_n;
    ucode_step_t  step;
    cpu_regs_t    regs;
    logic         step_valid;
    logic         step_ready;
    addr_t        bus_addr;
    byte_t        r_data;
    logic         rd_valid;
    logic         psel, penable, pwrite, pready;
    ppu_reg_idx_t paddr;
    byte_t        pwdata, prdata;

    // Shadow state for the reference
    byte_t     shadow_ram [WRAM_BYTES];
    byte_t     shadow_ppu [9];
    addr_t     latch_q = '0;
    byte_t     last_bus = '0;
    byte_t     read_buf = '0;
    byte_t     exp_reads [$];
    apb_xfer_t exp_apb [$];
    logic      rd_due = 1'b0;
    logic      timed_out = 1'b0;
    integer    seed = 79;
    int        errors = 0;
    int        checks = 0;
    int        test_errors = 0;
    int        tests_run = 0;
    string     test_name = "reset";

    always #2 clock = ~clock;

    cpu_mem_top cpu_mem_top_i (.*);
    ppu_reg_model ppu_reg_model_i (.*);

    function automatic logic [3:0] ppu_index(addr_t addr);
        return (addr == OAMDMA_ADDR) ? 4'd8 : {1'b0, addr[2:0]};
    endfunction

    // Expected bus address, write byte and read result of one step
    function automatic access_t predict(ucode_step_t s, cpu_regs_t r);
        access_t e;
        byte_t   status;
        status = {r.n, r.v, 2'b11, r.d, r.i, r.z, r.c};
        e = '0;
        e.addr = latch_q;
        if (s.state != STATE_NEITHER) begin
            e.addr = {(s.addr_hi_src == ADDRHI_RMEM) ? last_bus : r.pc[15:8], r.pc[7:0]};
            e.is_read = 1'b1;
        end else begin
            case (s.addr_lo_src)
                ADDRLO_PCLO:       e.addr[7:0] = r.pc[7:0];
                ADDRLO_RMEMBUFFER: e.addr[7:0] = read_buf;
                ADDRLO_RMEM:       e.addr[7:0] = last_bus;
                ADDRLO_ALUOUT:     e.addr[7:0] = r.alu_out;
                ADDRLO_SP:         e.addr[7:0] = r.sp;
                ADDRLO_HOLD:       ;
                // FF down to FA in enum order
                default:           e.addr[7:0] = 8'hFF - 8'(s.addr_lo_src);
            endcase
            case (s.addr_hi_src)
                ADDRHI_1:      e.addr[15:8] = 8'h01;
                ADDRHI_0:      e.addr[15:8] = 8'h00;
                ADDRHI_FF:     e.addr[15:8] = 8'hFF;
                ADDRHI_PCHI:   e.addr[15:8] = r.pc[15:8];
                ADDRHI_RMEM:   e.addr[15:8] = last_bus;
                ADDRHI_ALUOUT: e.addr[15:8] = r.alu_out;
                default:       ;
            endcase
            e.is_read  = (s.r_en == READ_EN_R);
            e.is_write = (s.r_en == READ_EN_W);
        end
        case (s.write_mem_src)
            WMEMSRC_PCHI:        e.wdata = r.pc[15:8];
            WMEMSRC_PCLO:        e.wdata = r.pc[7:0];
            WMEMSRC_STATUS_BS:   e.wdata = status;
            WMEMSRC_STATUS_BC:   e.wdata = status & 8'hEF;
            WMEMSRC_INSTR_STORE: e.wdata = (s.store_reg == STORE_A) ? r.a :
                                           (s.store_reg == STORE_X) ? r.x :
                                           (s.store_reg == STORE_Y) ? r.y : status;
            WMEMSRC_RMEM:        e.wdata = last_bus;
            WMEMSRC_ALUOUT:      e.wdata = r.alu_out;
            default:             e.wdata = 8'h00;
        endcase
        e.is_wram = (e.addr < WRAM_SPAN_END);
        e.is_ppu  = ((e.addr >= WRAM_SPAN_END) && (e.addr < PPU_SPAN_END))
                 || (e.addr == OAMDMA_ADDR);
        if (e.is_wram) begin
            e.rdata = shadow_ram[e.addr[10:0]];
        end else if (e.is_ppu) begin
            e.rdata = shadow_ppu[ppu_index(e.addr)];
        end else begin
            e.rdata = last_bus;
        end
        return e;
    endfunction

    task automatic check(string what, logic [15:0] expected, logic [15:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error [%s] %s: expected %h, got %h", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic flag(string msg);
        $display("In test %s: %s", test_name, msg);
        errors++;
        test_errors++;
    endtask

    // Checks each accepted step, read return and APB transfer
    always @(posedge clock) begin
        access_t   e;
        apb_xfer_t x;
        if (reset_n) begin
            if (rd_due) begin
                check("rd_valid latency", 1, rd_valid);
            end
            rd_due = 1'b0;
            if (psel) begin
                check("step_ready during APB", 0, step_ready);
            end
            if (step_valid && step_ready) begin
                e = predict(step, regs);
                check("bus_addr", e.addr, bus_addr);
                latch_q = e.addr;
                if (e.is_ppu && (e.is_read || e.is_write)) begin
                    exp_apb.push_back('{ppu_index(e.addr), e.is_write, e.wdata});
                end
                if (e.is_read) begin
                    exp_reads.push_back(e.rdata);
                    rd_due = !e.is_ppu;
                    if (e.is_wram || e.is_ppu) begin
                        last_bus = e.rdata;
                    end
                end else if (e.is_write && (e.is_wram || e.is_ppu)) begin
                    if (e.is_wram) begin
                        shadow_ram[e.addr[10:0]] = e.wdata;
                    end else begin
                        shadow_ppu[ppu_index(e.addr)] = e.wdata;
                    end
                    last_bus = e.wdata;
                end
            end
            if (rd_valid) begin
                assert (exp_reads.size() != 0) else flag("rd_valid with no read outstanding");
                if (exp_reads.size() != 0) begin
                    read_buf = exp_reads.pop_front();
                    check("r_data", read_buf, r_data);
                end
            end
            if (psel && penable && pready) begin
                assert (exp_apb.size() != 0) else flag("APB transfer with no PPU access");
                if (exp_apb.size() != 0) begin
                    x = exp_apb.pop_front();
                    check("paddr", x.paddr, paddr);
                    check("pwrite", x.pwrite, pwrite);
                    if (x.pwrite) begin
                        check("pwdata", x.pwdata, pwdata);
                    end else begin
                        // PPU read data follows in the next cycle
                        rd_due = 1'b1;
                    end
                end
            end
        end
    end

    function automatic ucode_step_t make_step(processor_state_t st, addr_lo_src_t lo,
                                              addr_hi_src_t hi, read_en_t en,
                                              wmem_src_t ws, store_reg_t sr);
        return '{st, lo, hi, en, ws, sr};
    endfunction

    task automatic finish_run();
        $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // Drives one step and returns at the edge that takes it
    task automatic issue_step(ucode_step_t s, cpu_regs_t r);
        int waited;
        waited = 0;
        @(negedge clock);
        step = s;
        regs = r;
        step_valid = 1'b1;
        while (!step_ready && waited < TIMEOUT_CYCLES) begin
            @(negedge clock);
            waited++;
        end
        if (!step_ready) begin
            $display("Timeout in test %s: step_ready stayed low", test_name);
            timed_out = 1'b1;
            finish_run();
        end else begin
            @(posedge clock);
        end
    endtask

    function automatic logic pending();
        return (exp_reads.size() != 0) || (exp_apb.size() != 0) || rd_due;
    endfunction

    task automatic end_test();
        int waited;
        waited = 0;
        @(negedge clock);
        step_valid = 1'b0;
        while (pending() && waited < TIMEOUT_CYCLES) begin
            @(negedge clock);
            waited++;
        end
        if (pending()) begin
            $display("Timeout in test %s: read data or APB transfer missing", test_name);
            timed_out = 1'b1;
            finish_run();
        end else begin
            tests_run++;
            $display("Test %-12s done, %0d errors", test_name, test_errors);
        end
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_errors = 0;
    endtask

    initial begin
        cpu_regs_t   r;
        addr_t       addrs [8];
        wmem_src_t   ws;
        ucode_step_t wr_pc;
        ucode_step_t rd_pc;
        wr_pc = make_step(STATE_NEITHER, ADDRLO_PCLO, ADDRHI_PCHI, READ_EN_W, WMEMSRC_ALUOUT,
                          STORE_A);
        rd_pc = make_step(STATE_NEITHER, ADDRLO_PCLO, ADDRHI_PCHI, READ_EN_R, WMEMSRC_NONE,
                          STORE_A);
        for (int k = 0; k < 9; k++) begin
            shadow_ppu[k] = '0;
        end
        reset_n = 1'b0;
        step_valid = 1'b0;
        step = make_step(STATE_NEITHER, ADDRLO_HOLD, ADDRHI_HOLD, READ_EN_NONE, WMEMSRC_NONE,
                         STORE_A);
        regs = '0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        begin_test("reset");
        check("step_ready", 1, step_ready);
        check("psel", 0, psel);
        check("penable", 0, penable);
        check("rd_valid", 0, rd_valid);
        check("r_data", 0, r_data);
        check("bus_addr", 0, bus_addr);
        end_test();

        // Write random locations, read back through another mirror
        begin_test("wram_mirror");
        r = '0;
        for (int k = 0; k < 8; k++) begin
            addrs[k] = addr_t'($random(seed)) & 16'h1FFF;
            r.pc = addrs[k];
            r.alu_out = byte_t'($random(seed));
            issue_step(wr_pc, r);
        end
        for (int k = 0; k < 8; k++) begin
            r.pc = addrs[k] ^ 16'(((k % 3) + 1) << 11);
            issue_step(rd_pc, r);
        end
        end_test();

        begin_test("addr_sources");
        r.pc = 16'h0010;
        r.alu_out = 8'h85;
        issue_step(wr_pc, r);
        r.pc = 16'h1234;
        r.alu_out = 8'h56;
        r.sp = 8'hFD;
        for (int lo = 0; lo <= int'(ADDRLO_HOLD); lo++) begin
            issue_step(make_step(STATE_NEITHER, addr_lo_src_t'(lo), ADDRHI_HOLD, READ_EN_NONE,
                                 WMEMSRC_NONE, STORE_A), r);
        end
        for (int hi = 0; hi <= int'(ADDRHI_HOLD); hi++) begin
            issue_step(make_step(STATE_NEITHER, ADDRLO_HOLD, addr_hi_src_t'(hi), READ_EN_NONE,
                                 WMEMSRC_NONE, STORE_A), r);
        end
        // Fetch and decode ignore the sources and read from PC
        r.pc = 16'h9ABC;
        issue_step(make_step(STATE_FETCH, ADDRLO_SP, ADDRHI_ALUOUT, READ_EN_NONE,
                             WMEMSRC_NONE, STORE_A), r);
        issue_step(make_step(STATE_DECODE, ADDRLO_HOLD, ADDRHI_RMEM, READ_EN_NONE,
                             WMEMSRC_NONE, STORE_A), r);
        end_test();

        begin_test("write_data");
        r.a = 8'h11;
        r.x = 8'h22;
        r.y = 8'h33;
        r.pc = 16'hC3A5;
        r.alu_out = 8'h77;
        for (int w = 0; w < 9; w++) begin
            ws = (w < 4) ? wmem_src_t'(w + 1) : (w < 8) ? WMEMSRC_INSTR_STORE : WMEMSRC_ALUOUT;
            r.sp = 8'hF0 + 8'(w);
            {r.n, r.v, r.d, r.i, r.z, r.c} = 6'(w * 11);
            issue_step(make_step(STATE_NEITHER, ADDRLO_SP, ADDRHI_1, READ_EN_W, ws,
                                 store_reg_t'(w % 4)), r);
            issue_step(make_step(STATE_NEITHER, ADDRLO_SP, ADDRHI_1, READ_EN_R, WMEMSRC_NONE,
                                 STORE_A), r);
        end
        end_test();

        // Writes at random mirrors, reads at the top mirror
        begin_test("ppu_port");
        for (int k = 0; k < 9; k++) begin
            r.pc = (k == 8) ? OAMDMA_ADDR : 16'h2000 + 16'(8 * ($random(seed) & 16'h3FF)) + 16'(k);
            r.alu_out = byte_t'($random(seed));
            issue_step(wr_pc, r);
        end
        for (int k = 0; k < 9; k++) begin
            r.pc = (k == 8) ? OAMDMA_ADDR : 16'h3FF8 + 16'(k);
            issue_step(rd_pc, r);
        end
        end_test();

        begin_test("open_bus");
        r.pc = 16'h0123;
        r.alu_out = 8'h5A;
        issue_step(wr_pc, r);
        r.pc = 16'h5000;
        issue_step(rd_pc, r);
        r.pc = 16'h2007;
        issue_step(rd_pc, r);
        r.pc = 16'h5000;
        issue_step(rd_pc, r);
        r.pc = 16'h6000;
        r.alu_out = 8'hC3;
        issue_step(wr_pc, r);
        r.pc = 16'h5000;
        issue_step(rd_pc, r);
        // Work RAM read taken in the PPU completion cycle
        r.pc = 16'h2007;
        issue_step(rd_pc, r);
        r.pc = 16'h0123;
        issue_step(rd_pc, r);
        r.pc = 16'h5000;
        issue_step(rd_pc, r);
        end_test();

        finish_run();
    end

endmodule : tb_cpu_mem_top

/* verification/ppu_reg_model.sv */
`timescale 1ns/1ps

module ppu_reg_model import nes_cpu_pkg::*; (
    input  logic         clock,
    input  logic         reset_n,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  ppu_reg_idx_t paddr,
    input  byte_t        pwdata,
    output byte_t        prdata,
    output logic         pready
);

    byte_t      ppu_regs [9];
    logic [1:0] wait_left;
    integer     seed = 79;

    // Wait states are drawn in the setup phase
    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wait_left <= '0;
            for (int k = 0; k < 9; k++) begin
                ppu_regs[k] <= '0;
            end
        end else begin
            if (psel && !penable) begin
                wait_left <= 2'($unsigned($random(seed)) % 4);
            end else if (psel && penable && wait_left != 0) begin
                wait_left <= wait_left - 2'd1;
            end
            if (psel && penable && pready && pwrite) begin
                ppu_regs[paddr] <= pwdata;
            end
        end
    end

    assign pready = psel && penable && (wait_left == 0);
    assign prdata = (paddr < 9) ? ppu_regs[paddr] : '0;

endmodule : ppu_reg_model

/* hw/cpu_mem_top.sv */
`timescale 1ns/1ps

module cpu_mem_top import nes_cpu_pkg::*; (
    input  logic         clock,
    input  logic         reset_n,

    // Micro-step from the core's sequencer
    input  ucode_step_t  step,
    input  cpu_regs_t    regs,
    input  logic         step_valid,
    output logic         step_ready,
    output addr_t        bus_addr,
    output byte_t        r_data,
    output logic         rd_valid,

    // PPU register port
    output logic         psel,
    output logic         penable,
    output logic         pwrite,
    output ppu_reg_idx_t paddr,
    output byte_t        pwdata,
    input  byte_t        prdata,
    input  logic         pready
);

    addr_t      next_addr;
    logic [1:0] addr_en;
    logic       mem_r_en;
    logic       access_en;
    byte_t      w_data;
    byte_t      r_data_buffer;
    logic       advance;
    ppu_req_t   ppu_req;
    logic       ppu_req_valid;
    logic       ppu_busy;
    byte_t      ppu_rdata;
    logic       ppu_rdone;

    // Only the PPU port pushes back on the core
    assign step_ready = !ppu_busy;
    assign advance    = step_valid && step_ready;

    mem_inputs mem_inputs_i (
        .step          (step),
        .regs          (regs),
        .r_data        (r_data),
        .r_data_buffer (r_data_buffer),
        .next_addr     (next_addr),
        .addr_en       (addr_en),
        .mem_r_en      (mem_r_en),
        .access_en     (access_en),
        .w_data        (w_data)
    );

    cpu_bus_latches cpu_bus_latches_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .advance       (advance),
        .addr_en       (addr_en),
        .next_addr     (next_addr),
        .r_data        (r_data),
        .rd_valid      (rd_valid),
        .bus_addr      (bus_addr),
        .r_data_buffer (r_data_buffer)
    );

    cpu_memory cpu_memory_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .advance       (advance),
        .bus_addr      (bus_addr),
        .access_en     (access_en),
        .mem_r_en      (mem_r_en),
        .w_data        (w_data),
        .ppu_rdata     (ppu_rdata),
        .ppu_rdone     (ppu_rdone),
        .ppu_req       (ppu_req),
        .ppu_req_valid (ppu_req_valid),
        .r_data        (r_data),
        .rd_valid      (rd_valid)
    );

    ppu_reg_apb_bridge ppu_reg_apb_bridge_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .ppu_req       (ppu_req),
        .ppu_req_valid (ppu_req_valid),
        .ppu_busy      (ppu_busy),
        .ppu_rdata     (ppu_rdata),
        .ppu_rdone     (ppu_rdone),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready)
    );

endmodule : cpu_mem_top

/* hw/ppu_reg_apb_bridge.sv */
`timescale 1ns/1ps

module ppu_reg_apb_bridge import nes_cpu_pkg::*; (
    input  logic         clock,
    input  logic         reset_n,
    input  ppu_req_t     ppu_req,
    input  logic         ppu_req_valid,
    output logic         ppu_busy,
    output byte_t        ppu_rdata,
    output logic         ppu_rdone,
    output logic         psel,
    output logic         penable,
    output logic         pwrite,
    output ppu_reg_idx_t paddr,
    output byte_t        pwdata,
    input  byte_t        prdata,
    input  logic         pready
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_t;

    apb_state_t state;
    ppu_req_t   req_q;
    logic       done;

    assign done = (state == ACCESS) && pready;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (ppu_req_valid) begin
                        state <= SETUP;
                    end
                end
                SETUP:   state <= ACCESS;
                default: begin
                    // Stay in access until the completer is ready
                    if (pready) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == IDLE && ppu_req_valid) begin
            req_q <= ppu_req;
        end
        if (done && !req_q.rw) begin
            ppu_rdata <= prdata;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ppu_rdone <= 1'b0;
        end else begin
            ppu_rdone <= done && !req_q.rw;
        end
    end

    assign ppu_busy = (state != IDLE);
    assign psel     = (state != IDLE);
    assign penable  = (state == ACCESS);
    assign pwrite   = req_q.rw;
    assign paddr    = ppu_reg_idx_t'(req_q.sel);
    assign pwdata   = req_q.wdata;

endmodule : ppu_reg_apb_bridge

/* hw/cpu_memory.sv */
`timescale 1ns/1ps

module cpu_memory import nes_cpu_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     advance,
    input  addr_t    bus_addr,
    input  logic     access_en,
    input  logic     mem_r_en,
    input  byte_t    w_data,
    input  byte_t    ppu_rdata,
    input  logic     ppu_rdone,
    output ppu_req_t ppu_req,
    output logic     ppu_req_valid,
    output byte_t    r_data,
    output logic     rd_valid
);

    byte_t wram [WRAM_BYTES];

    logic [$clog2(WRAM_BYTES)-1:0] wram_idx;
    logic  hit_wram;
    logic  hit_ppu;
    logic  access;
    byte_t bus_byte;
    logic  rd_valid_q;

    // 2 KB mirrored four times below 0x2000
    assign wram_idx = bus_addr[$clog2(WRAM_BYTES)-1:0];
    assign hit_wram = (bus_addr < WRAM_SPAN_END);
    assign hit_ppu  = ((bus_addr >= WRAM_SPAN_END) && (bus_addr < PPU_SPAN_END))
                   || (bus_addr == OAMDMA_ADDR);
    assign access   = advance && access_en;

    always_comb begin
        if (bus_addr == OAMDMA_ADDR) begin
            ppu_req.sel = OAMDMA;
        end else begin
            // Eight registers repeat every 8 bytes
            ppu_req.sel = reg_t'({1'b0, bus_addr[2:0]});
        end
        ppu_req.rw    = !mem_r_en;
        ppu_req.wdata = w_data;
    end

    assign ppu_req_valid = access && hit_ppu;

    always_ff @(posedge clock) begin
        if (access && hit_wram && !mem_r_en) begin
            wram[wram_idx] <= w_data;
        end
    end

    // Last byte seen on the data bus, also the open-bus value
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            bus_byte   <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= access && mem_r_en && !hit_ppu;
            // A step taken in the PPU completion cycle is the later access
            if (access && mem_r_en && hit_wram) begin
                bus_byte <= wram[wram_idx];
            end else if (access && !mem_r_en && (hit_wram || hit_ppu)) begin
                bus_byte <= w_data;
            end else if (ppu_rdone) begin
                bus_byte <= ppu_rdata;
            end
        end
    end

    // PPU read data is passed on in its completion cycle
    assign r_data   = ppu_rdone ? ppu_rdata : bus_byte;
    assign rd_valid = rd_valid_q || ppu_rdone;

endmodule : cpu_memory

/* hw/cpu_bus_latches.sv */
`timescale 1ns/1ps

module cpu_bus_latches import nes_cpu_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       advance,
    input  logic [1:0] addr_en,
    input  addr_t      next_addr,
    input  byte_t      r_data,
    input  logic       rd_valid,
    output addr_t      bus_addr,
    output byte_t      r_data_buffer
);

    addr_t addr_q;

    // New bytes show on the pins in the cycle the step is taken
    always_comb begin
        bus_addr = addr_q;
        if (advance && addr_en[0]) begin
            bus_addr[7:0] = next_addr[7:0];
        end
        if (advance && addr_en[1]) begin
            bus_addr[15:8] = next_addr[15:8];
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            addr_q <= '0;
        end else if (advance) begin
            addr_q <= bus_addr;
        end
    end

    // Previous read byte, kept for indirect address steps
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            r_data_buffer <= '0;
        end else if (rd_valid) begin
            r_data_buffer <= r_data;
        end
    end

endmodule : cpu_bus_latches

/* hw/mem_inputs.sv */
`timescale 1ns/1ps

module mem_inputs import nes_cpu_pkg::*; (
    input  ucode_step_t step,
    input  cpu_regs_t   regs,
    input  byte_t       r_data,
    input  byte_t       r_data_buffer,
    output addr_t       next_addr,
    output logic [1:0]  addr_en,
    output logic        mem_r_en,
    output logic        access_en,
    output byte_t       w_data
);

    logic  fetch_or_decode;
    byte_t status_bs;
    byte_t status_bc;

    assign fetch_or_decode = (step.state != STATE_NEITHER);

    // NV-BDIZC, bit 5 always set
    assign status_bs = {regs.n, regs.v, 1'b1, 1'b1, regs.d, regs.i, regs.z, regs.c};
    assign status_bc = {regs.n, regs.v, 1'b1, 1'b0, regs.d, regs.i, regs.z, regs.c};

    always_comb begin
        next_addr = '0;
        addr_en   = 2'b11;
        mem_r_en  = 1'b1;
        access_en = 1'b1;

        if (fetch_or_decode) begin
            // Opcode and operand fetches always come from PC
            next_addr[7:0] = regs.pc[7:0];
            if (step.addr_hi_src == ADDRHI_RMEM) begin
                next_addr[15:8] = r_data;
            end else begin
                next_addr[15:8] = regs.pc[15:8];
            end
        end else begin
            case (step.addr_lo_src)
                ADDRLO_FF:         next_addr[7:0] = 8'hFF;
                ADDRLO_FE:         next_addr[7:0] = 8'hFE;
                ADDRLO_FD:         next_addr[7:0] = 8'hFD;
                ADDRLO_FC:         next_addr[7:0] = 8'hFC;
                ADDRLO_FB:         next_addr[7:0] = 8'hFB;
                ADDRLO_FA:         next_addr[7:0] = 8'hFA;
                ADDRLO_PCLO:       next_addr[7:0] = regs.pc[7:0];
                ADDRLO_RMEMBUFFER: next_addr[7:0] = r_data_buffer;
                ADDRLO_RMEM:       next_addr[7:0] = r_data;
                ADDRLO_ALUOUT:     next_addr[7:0] = regs.alu_out;
                ADDRLO_SP:         next_addr[7:0] = regs.sp;
                default:           addr_en[0] = 1'b0;
            endcase

            case (step.addr_hi_src)
                ADDRHI_1:      next_addr[15:8] = 8'h01;
                ADDRHI_0:      next_addr[15:8] = 8'h00;
                ADDRHI_FF:     next_addr[15:8] = 8'hFF;
                ADDRHI_PCHI:   next_addr[15:8] = regs.pc[15:8];
                ADDRHI_RMEM:   next_addr[15:8] = r_data;
                ADDRHI_ALUOUT: next_addr[15:8] = regs.alu_out;
                default:       addr_en[1] = 1'b0;
            endcase

            case (step.r_en)
                READ_EN_W: mem_r_en = 1'b0;
                READ_EN_NONE: begin
                    // Address-only step
                    access_en = 1'b0;
                end
                default: mem_r_en = 1'b1;
            endcase
        end
    end

    always_comb begin
        case (step.write_mem_src)
            WMEMSRC_PCHI:      w_data = regs.pc[15:8];
            WMEMSRC_PCLO:      w_data = regs.pc[7:0];
            WMEMSRC_STATUS_BS: w_data = status_bs;
            WMEMSRC_STATUS_BC: w_data = status_bc;
            WMEMSRC_INSTR_STORE: begin
                case (step.store_reg)
                    STORE_A: w_data = regs.a;
                    STORE_X: w_data = regs.x;
                    STORE_Y: w_data = regs.y;
                    // PHP pushes with B set
                    default: w_data = status_bs;
                endcase
            end
            WMEMSRC_RMEM:      w_data = r_data;
            WMEMSRC_ALUOUT:    w_data = regs.alu_out;
            default:           w_data = '0;
        endcase
    end

endmodule : mem_inputs

/* hw/nes_cpu_pkg.sv */
package nes_cpu_pkg;

    // Widths fixed by the 6502 bus
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [3:0]  ppu_reg_idx_t;

    // CPU memory map
    localparam int unsigned WRAM_BYTES = 2048;
    localparam addr_t WRAM_SPAN_END = 16'h2000;
    localparam addr_t PPU_SPAN_END  = 16'h4000;
    localparam addr_t OAMDMA_ADDR   = 16'h4014;

    typedef enum logic [1:0] {
        STATE_FETCH,
        STATE_DECODE,
        STATE_NEITHER
    } processor_state_t;

    typedef enum logic [3:0] {
        ADDRLO_FF, ADDRLO_FE, ADDRLO_FD, ADDRLO_FC, ADDRLO_FB, ADDRLO_FA,
        ADDRLO_PCLO,
        ADDRLO_RMEMBUFFER,
        ADDRLO_RMEM,
        ADDRLO_ALUOUT,
        ADDRLO_SP,
        ADDRLO_HOLD
    } addr_lo_src_t;

    typedef enum logic [2:0] {
        ADDRHI_1, ADDRHI_0, ADDRHI_FF,
        ADDRHI_PCHI,
        ADDRHI_RMEM,
        ADDRHI_ALUOUT,
        ADDRHI_HOLD
    } addr_hi_src_t;

    typedef enum logic [1:0] {
        READ_EN_R,
        READ_EN_W,
        READ_EN_NONE
    } read_en_t;

    typedef enum logic [2:0] {
        WMEMSRC_NONE, WMEMSRC_PCHI, WMEMSRC_PCLO,
        WMEMSRC_STATUS_BS, WMEMSRC_STATUS_BC,
        WMEMSRC_INSTR_STORE, WMEMSRC_RMEM, WMEMSRC_ALUOUT
    } wmem_src_t;

    typedef enum logic [1:0] {
        STORE_A, STORE_X, STORE_Y, STORE_STATUS
    } store_reg_t;

    // Index doubles as the APB paddr
    typedef enum logic [3:0] {
        PPUCTRL   = 4'd0, PPUMASK   = 4'd1, PPUSTATUS = 4'd2,
        OAMADDR   = 4'd3, OAMDATA   = 4'd4, PPUSCROLL = 4'd5,
        PPUADDR   = 4'd6, PPUDATA   = 4'd7, OAMDMA    = 4'd8
    } reg_t;

    typedef struct packed {
        processor_state_t state;
        addr_lo_src_t     addr_lo_src;
        addr_hi_src_t     addr_hi_src;
        read_en_t         r_en;
        wmem_src_t        write_mem_src;
        store_reg_t       store_reg;
    } ucode_step_t;

    typedef struct packed {
        byte_t a;
        byte_t x;
        byte_t y;
        byte_t sp;
        addr_t pc;
        byte_t alu_out;
        logic  n, v, d, i, z, c;
    } cpu_regs_t;

    // rw high means write, as on pwrite
    typedef struct packed {
        reg_t  sel;
        logic  rw;
        byte_t wdata;
    } ppu_req_t;

endpackage : nes_cpu_pkg
